// ==== hw/controlPkg.sv ====
`default_nettype none

package controlPkg;

    // primary opcodes, 0 marks the R-type group
    typedef enum logic [5:0] {
        opR    = 6'b000000,
        opJ    = 6'b000010,
        opJal  = 6'b000011,
        opAddi = 6'b001000,
        opSlti = 6'b001010,
        opLui  = 6'b001111,
        opLb   = 6'b100000,
        opLh   = 6'b100001,
        opLw   = 6'b100011,
        opSb   = 6'b101000,
        opSh   = 6'b101001,
        opSw   = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnSlt  = 6'b101010
    } funct_t;

    typedef enum logic [4:0] {
        classNop, classAdd, classSub, classAnd, classSlt,
        classSll, classSrl, classSra, classSllv, classSrav, classJr,
        classAddi, classSlti, classLui, classJ, classJal,
        classLw, classLh, classLb, classSw, classSh, classSb
    } instrClass_t;

    typedef enum logic [1:0] {
        phaseReset, phaseFetch, phaseDecode, phaseExec
    } phase_t;

    typedef logic [3:0] step_t;

    typedef struct packed {
        logic [1:0] iord;
        logic       shiftSrc;
        logic       shiftAmt;
        logic       srcRead;
        logic [2:0] srcWrite;
        logic [3:0] srcData;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic [2:0] pcSource;
    } muxSel_t;

    typedef struct packed {
        logic       pcWrite;
        logic       seControl;
        logic       memWrite;
        logic [1:0] ssControl;
        logic       irWrite;
        logic [1:0] lsControl;
        logic [2:0] shiftControl;
        logic       regWrite;
        logic [2:0] aluControl;
        logic       aluOutControl;
        logic       aControl;
        logic       bControl;
    } unitCtrl_t;

    // 37 bits, selects in the upper part
    typedef struct packed {
        muxSel_t   sel;
        unitCtrl_t unit;
    } controlWord_t;

    localparam logic [2:0] aluPass = 3'd0;
    localparam logic [2:0] aluAdd  = 3'd1;
    localparam logic [2:0] aluSub  = 3'd2;
    localparam logic [2:0] aluAnd  = 3'd3;
    localparam logic [2:0] aluSlt  = 3'd7;

    localparam logic [2:0] shiftLoad       = 3'd1;
    localparam logic [2:0] shiftLeft       = 3'd2;
    localparam logic [2:0] shiftRightLogic = 3'd3;
    localparam logic [2:0] shiftRightArith = 3'd4;

    localparam logic [1:0] lsWord = 2'd1;
    localparam logic [1:0] lsHalf = 2'd2;
    localparam logic [1:0] lsByte = 2'd3;
    localparam logic [1:0] ssWord = 2'd1;
    localparam logic [1:0] ssHalf = 2'd2;
    localparam logic [1:0] ssByte = 2'd3;

    localparam logic [3:0] srcDataAluOut = 4'd0;
    localparam logic [3:0] srcDataMem    = 4'd1;
    localparam logic [3:0] srcDataLui    = 4'd5;
    localparam logic [3:0] srcDataShift  = 4'd7;
    localparam logic [3:0] srcDataSpInit = 4'd8;

    localparam logic [2:0] srcWriteRt = 3'd0;
    localparam logic [2:0] srcWriteRd = 3'd1;
    localparam logic [2:0] srcWriteSp = 3'd2;
    localparam logic [2:0] srcWriteRa = 3'd5;

endpackage

`default_nettype wire

// ==== hw/opDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module opDecoder import controlPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  opcode_t     opcode,
    input  funct_t      funct,
    input  logic        latchClass,
    output instrClass_t instrClass
);

    function automatic instrClass_t classify(opcode_t op, funct_t fn);
        instrClass_t cls;
        cls = classNop;
        if (op == opR) begin
            // R-type is split by funct
            case (fn)
                fnAdd:   cls = classAdd;
                fnSub:   cls = classSub;
                fnAnd:   cls = classAnd;
                fnSlt:   cls = classSlt;
                fnSll:   cls = classSll;
                fnSrl:   cls = classSrl;
                fnSra:   cls = classSra;
                fnSllv:  cls = classSllv;
                fnSrav:  cls = classSrav;
                fnJr:    cls = classJr;
                default: cls = classNop;
            endcase
        end else begin
            case (op)
                opAddi:  cls = classAddi;
                opSlti:  cls = classSlti;
                opLui:   cls = classLui;
                opJ:     cls = classJ;
                opJal:   cls = classJal;
                opLw:    cls = classLw;
                opLh:    cls = classLh;
                opLb:    cls = classLb;
                opSw:    cls = classSw;
                opSh:    cls = classSh;
                opSb:    cls = classSb;
                default: cls = classNop;
            endcase
        end
        return cls;
    endfunction

    // class is held for the whole execute phase
    always_ff @(posedge clk) begin
        if (reset) begin
            instrClass <= classNop;
        end else if (latchClass) begin
            instrClass <= classify(opcode, funct);
        end
    end

endmodule

`default_nettype wire

// ==== hw/stepSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module stepSequencer import controlPkg::*; #(
    parameter int FETCH_WAIT = 2,
    parameter int MEM_WAIT   = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  instrClass_t instrClass,
    output phase_t      phase,
    output step_t       step,
    output logic        latchClass
);

    step_t lastStep;

    // last execute step, one less than the execute length
    function automatic step_t execLast(instrClass_t cls);
        step_t last;
        case (cls)
            classAdd, classSub, classAnd, classSlt,
            classAddi, classSlti, classJal:
                last = 4'd1;
            classSll, classSrl, classSra, classSllv, classSrav:
                last = 4'd3;
            classLw, classLh, classLb, classSw, classSh, classSb:
                last = step_t'(MEM_WAIT + 1);
            default:
                last = 4'd0;
        endcase
        return last;
    endfunction

    function automatic phase_t nextPhase(phase_t ph);
        phase_t nxt;
        case (ph)
            phaseFetch:  nxt = phaseDecode;
            phaseDecode: nxt = phaseExec;
            default:     nxt = phaseFetch;
        endcase
        return nxt;
    endfunction

    always_comb begin
        case (phase)
            phaseFetch:  lastStep = step_t'(FETCH_WAIT);
            phaseDecode: lastStep = 4'd1;
            phaseExec:   lastStep = execLast(instrClass);
            default:     lastStep = 4'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phaseReset;
            step  <= '0;
        end else if (step == lastStep) begin
            phase <= nextPhase(phase);
            step  <= '0;
        end else begin
            step <= step + 4'd1;
        end
    end

    // second decode cycle, opcode and funct are stable by then
    assign latchClass = (phase == phaseDecode) && (step == lastStep);

    stepInRange: assert property (@(posedge clk) disable iff (reset)
        step <= lastStep);

endmodule

`default_nettype wire

// ==== hw/controlEncoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlEncoder import controlPkg::*; #(
    parameter int FETCH_WAIT = 2,
    parameter int MEM_WAIT   = 2
) (
    input  logic         clk,
    input  phase_t       phase,
    input  step_t        step,
    input  instrClass_t  instrClass,
    output controlWord_t ctrl,
    output logic         resetOut
);

    localparam step_t fetchLast = step_t'(FETCH_WAIT);
    localparam step_t memLast   = step_t'(MEM_WAIT + 1);

    function automatic logic [2:0] aluCode(instrClass_t cls);
        case (cls)
            classSub: return aluSub;
            classAnd: return aluAnd;
            classSlt: return aluSlt;
            default:  return aluAdd;
        endcase
    endfunction

    function automatic logic [2:0] shiftDir(instrClass_t cls);
        case (cls)
            classSll, classSllv: return shiftLeft;
            classSrl:            return shiftRightLogic;
            default:             return shiftRightArith;
        endcase
    endfunction

    // same size code serves loads and stores
    function automatic logic [1:0] memSize(instrClass_t cls);
        case (cls)
            classLw, classSw: return lsWord;
            classLh, classSh: return lsHalf;
            default:          return lsByte;
        endcase
    endfunction

    always_comb begin
        ctrl     = '0;
        resetOut = 1'b0;
        case (phase)
            phaseReset: begin
                // stack pointer init only
                resetOut           = 1'b1;
                ctrl.unit.regWrite = 1'b1;
                ctrl.sel.srcWrite  = srcWriteSp;
                ctrl.sel.srcData   = srcDataSpInit;
            end
            phaseFetch: begin
                ctrl.unit.aluControl = aluAdd;
                ctrl.sel.aluSrcB     = 2'd1;
                if (step == fetchLast) begin
                    ctrl.unit.pcWrite = 1'b1;
                    ctrl.unit.irWrite = 1'b1;
                end
            end
            phaseDecode: begin
                ctrl.unit.aControl      = 1'b1;
                ctrl.unit.bControl      = 1'b1;
                ctrl.unit.aluOutControl = 1'b1;
                ctrl.unit.seControl     = 1'b1;
                ctrl.sel.aluSrcB        = 2'd3;
                ctrl.unit.aluControl    = aluAdd;
            end
            phaseExec: begin
                case (instrClass)
                    classAdd, classSub, classAnd, classSlt: begin
                        ctrl.sel.aluSrcA     = 2'd1;
                        ctrl.unit.aluControl = aluCode(instrClass);
                        if (step == 4'd0) begin
                            ctrl.unit.aluOutControl = 1'b1;
                        end else begin
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.srcWrite  = srcWriteRd;
                            ctrl.sel.srcData   = srcDataAluOut;
                        end
                    end
                    classAddi: begin
                        ctrl.sel.aluSrcA = 2'd1;
                        ctrl.sel.aluSrcB = 2'd2;
                        if (step == 4'd0) begin
                            ctrl.unit.aluOutControl = 1'b1;
                            ctrl.unit.aluControl    = aluAdd;
                        end else begin
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.srcWrite  = srcWriteRt;
                        end
                    end
                    classSlti: begin
                        if (step == 4'd0) begin
                            ctrl.sel.aluSrcA        = 2'd1;
                            ctrl.sel.aluSrcB        = 2'd2;
                            ctrl.unit.aluControl    = aluSlt;
                            ctrl.unit.aluOutControl = 1'b1;
                            ctrl.unit.seControl     = 1'b1;
                        end else begin
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.srcWrite  = srcWriteRd;
                            ctrl.sel.srcData   = srcDataAluOut;
                        end
                    end
                    classSll, classSrl, classSra, classSllv, classSrav: begin
                        // immediate shamt for the fixed shifts, rs otherwise
                        ctrl.sel.shiftSrc = instrClass inside {classSll, classSrl, classSra};
                        ctrl.sel.shiftAmt = ctrl.sel.shiftSrc;
                        if (step < 4'd2) begin
                            ctrl.unit.shiftControl = shiftLoad;
                        end else if (step == 4'd2) begin
                            ctrl.unit.shiftControl = shiftDir(instrClass);
                        end else begin
                            ctrl.sel.srcData   = srcDataShift;
                            ctrl.sel.srcWrite  = srcWriteRd;
                            ctrl.unit.regWrite = 1'b1;
                        end
                    end
                    classJr: begin
                        ctrl.sel.aluSrcA  = 2'd1;
                        ctrl.sel.pcSource = 3'd0;
                        ctrl.unit.pcWrite = 1'b1;
                    end
                    classJ: begin
                        ctrl.sel.pcSource = 3'd2;
                        ctrl.unit.pcWrite = 1'b1;
                    end
                    classJal: begin
                        if (step == 4'd0) begin
                            // return address through the ALU
                            ctrl.unit.aluControl    = aluPass;
                            ctrl.unit.aluOutControl = 1'b1;
                        end else begin
                            ctrl.unit.pcWrite  = 1'b1;
                            ctrl.sel.pcSource  = 3'd2;
                            ctrl.unit.regWrite = 1'b1;
                            ctrl.sel.srcWrite  = srcWriteRa;
                        end
                    end
                    classLui: begin
                        ctrl.sel.srcData   = srcDataLui;
                        ctrl.sel.srcWrite  = srcWriteRt;
                        ctrl.unit.regWrite = 1'b1;
                    end
                    classLw, classLh, classLb, classSw, classSh, classSb: begin
                        if (step == 4'd0) begin
                            ctrl.sel.aluSrcA     = 2'd1;
                            ctrl.sel.aluSrcB     = 2'd3;
                            ctrl.unit.aluControl = aluAdd;
                            ctrl.unit.seControl  = 1'b1;
                        end else if (step != memLast) begin
                            ctrl.sel.iord = 2'd1;
                        end else if (instrClass inside {classLw, classLh, classLb}) begin
                            ctrl.unit.lsControl = memSize(instrClass);
                            ctrl.sel.srcData    = srcDataMem;
                            ctrl.sel.srcWrite   = srcWriteRt;
                            ctrl.unit.regWrite  = 1'b1;
                        end else begin
                            ctrl.unit.ssControl = memSize(instrClass);
                            ctrl.unit.memWrite  = 1'b1;
                        end
                    end
                    default: begin
                        // unknown code, one idle cycle
                        ctrl = '0;
                    end
                endcase
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    noRegAndMemWrite: assert property (@(posedge clk)
        !(ctrl.unit.regWrite && ctrl.unit.memWrite));

    // instruction load only at the end of fetch, decode must follow
    irWriteInFetch: assert property (@(posedge clk)
        ctrl.unit.irWrite |-> phase == phaseFetch ##1 phase == phaseDecode);

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit import controlPkg::*; #(
    parameter int FETCH_WAIT = 2,
    parameter int MEM_WAIT   = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  opcode_t      opcode,
    input  funct_t       funct,
    output controlWord_t ctrl,
    output logic         resetOut
);

    instrClass_t instrClass;
    phase_t      phase;
    step_t       step;
    logic        latchClass;

    opDecoder decoder0 (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .latchClass (latchClass),
        .instrClass (instrClass)
    );

    stepSequencer #(
        .FETCH_WAIT (FETCH_WAIT),
        .MEM_WAIT   (MEM_WAIT)
    ) sequencer0 (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .phase      (phase),
        .step       (step),
        .latchClass (latchClass)
    );

    controlEncoder #(
        .FETCH_WAIT (FETCH_WAIT),
        .MEM_WAIT   (MEM_WAIT)
    ) encoder0 (
        .clk        (clk),
        .phase      (phase),
        .step       (step),
        .instrClass (instrClass),
        .ctrl       (ctrl),
        .resetOut   (resetOut)
    );

endmodule

`default_nettype wire

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb import controlPkg::*; ();

    localparam int FETCH_WAIT      = 2;
    localparam int MEM_WAIT        = 2;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_LINE = 20;

    logic         clk;
    logic         reset;
    opcode_t      opcode;
    funct_t       funct;
    controlWord_t ctrl;
    logic         resetOut;

    logic [5:0]  opcodeList [$];
    logic [5:0]  functList [$];
    int          execLenList [$];
    logic [36:0] wordList [$];

    logic goldenLoaded = 1'b0;
    int   cycleCount;
    int   lastIrWrite;
    int   lastExecLen;

    controlUnit #(
        .FETCH_WAIT (FETCH_WAIT),
        .MEM_WAIT   (MEM_WAIT)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // lines starting with # are skipped
    task automatic readGolden();
        int          fd;
        int          n;
        string       line;
        logic [5:0]  op;
        logic [5:0]  fn;
        int          len;
        logic [36:0] word;
        fd = $fopen("verification/controlUnitGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file verification/controlUnitGolden.txt");
            $display("test failed");
            $fatal(1, "no golden file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %d %h", op, fn, len, word);
                if (n == 4) begin
                    opcodeList.push_back(op);
                    functList.push_back(fn);
                    execLenList.push_back(len);
                    wordList.push_back(word);
                end
            end
        end
        $fclose(fd);
    endtask

    // checks common to every cycle after reset, sampled at the falling edge
    task automatic checkCycle(input string name, input int k, input int execLen);
        cycleCount++;
        checkValue({name, " resetOut"}, 0, resetOut);
        checkValue({name, " regWrite with memWrite"}, 0,
                   ctrl.unit.regWrite & ctrl.unit.memWrite);
        if (ctrl.unit.irWrite) begin
            if (lastIrWrite >= 0) begin
                checkValue({name, " irWrite spacing"}, FETCH_WAIT + 3 + lastExecLen,
                           cycleCount - lastIrWrite);
            end
            lastIrWrite = cycleCount;
            lastExecLen = execLen;
        end
        checkValue({name, " irWrite"}, k == FETCH_WAIT + 1, ctrl.unit.irWrite);
        checkValue({name, " irWrite with pcWrite"}, k == FETCH_WAIT + 1,
                   ctrl.unit.irWrite & ctrl.unit.pcWrite);
    endtask

    initial begin
        wait (goldenLoaded);
        repeat (opcodeList.size() * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired, the instruction sequence did not finish in time");
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        controlWord_t spInit;
        string        name;
        int           execLen;
        int           instrLen;
        reset       = 1'b1;
        opcode      = opR;
        funct       = fnSll;
        cycleCount  = 0;
        lastIrWrite = -1;
        lastExecLen = 0;

        readGolden();
        if (opcodeList.size() == 0) begin
            $display("the golden file holds no instruction lines");
            $display("test failed");
            $fatal(1, "empty golden file");
        end
        goldenLoaded = 1'b1;

        // stack pointer init word
        spInit              = '0;
        spInit.unit.regWrite = 1'b1;
        spInit.sel.srcWrite  = srcWriteSp;
        spInit.sel.srcData   = srcDataSpInit;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            checkValue("reset resetOut", 1, resetOut);
            checkValue("reset word", spInit, ctrl);
        end

        for (int i = 0; i < opcodeList.size(); i++) begin
            name     = $sformatf("line %0d op %h fn %h", i, opcodeList[i], functList[i]);
            execLen  = execLenList[i];
            instrLen = FETCH_WAIT + 3 + execLen;
            for (int k = 1; k <= instrLen; k++) begin
                @(posedge clk);
                if (k == 1) begin
                    opcode <= opcode_t'(opcodeList[i]);
                    funct  <= funct_t'(functList[i]);
                end
                @(negedge clk);
                checkCycle(name, k, execLen);
                if (k == instrLen) begin
                    checkValue({name, " final word"}, wordList[i], ctrl);
                end
            end
        end

        // one more fetch closes the spacing check of the last line
        for (int k = 1; k <= FETCH_WAIT + 1; k++) begin
            @(posedge clk);
            @(negedge clk);
            checkCycle("trailing fetch", k, 0);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== controlUnit.f ====
hw/controlPkg.sv
hw/opDecoder.sv
hw/stepSequencer.sv
hw/controlEncoder.sv
hw/controlUnit.sv
verification/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: controlUnit

sources:
  - hw/controlPkg.sv
  - hw/opDecoder.sv
  - hw/stepSequencer.sv
  - hw/controlEncoder.sv
  - hw/controlUnit.sv
  - target: test
    files:
      - verification/controlUnitTb.sv

// ==== verification/controlUnitGolden.txt ====
# opcode (hex) funct (hex) execute length (cycles) final control word (37 bits, hex)
# funct is ignored for non R-type opcodes
00 20 2 0020800048 add
00 22 2 0020800050 sub
00 24 2 0020800058 and
00 2a 2 0020800078 slt
00 00 4 062e000040 sll
00 02 4 062e000040 srl
00 03 4 062e000040 sra
00 04 4 002e000040 sllv
00 07 4 002e000040 srav
00 08 1 0000820000 jr
08 00 2 0000c00040 addi
0a 00 2 0020000040 slti
0f 00 1 000a000040 lui
02 00 1 00000a0000 j
03 00 2 00a00a0040 jal
23 00 4 0002000440 lw
21 00 4 0002000840 lh
20 00 4 0002000c40 lb
2b 00 4 000000a000 sw
29 00 4 000000c000 sh
28 00 4 000000e000 sb
3f 00 1 0000000000 unknown opcode
00 3f 1 0000000000 unknown funct
